/* hdl/esaxi_pkg.sv */
`default_nettype none

package esaxi_pkg;

   // ##############################
   // widths with a meaning
   // ##############################
   localparam int PACKET_W = 104;

   typedef logic [31:0]         addr_t;     // mesh and axi address
   typedef logic [31:0]         data_t;
   typedef logic [3:0]          strb_t;     // one bit per byte lane
   typedef logic [1:0]          resp_t;
   typedef logic [1:0]          datamode_t; // 0 byte, 1 halfword, 2 word
   typedef logic [PACKET_W-1:0] packet_t;

   // packet field low bits, lsb first
   localparam int WRITE_LSB    = 0;
   localparam int DATAMODE_LSB = 1;
   localparam int CTRLMODE_LSB = 3;  // 5 bits, always zero here
   localparam int DSTADDR_LSB  = 8;
   localparam int DATA_LSB     = 40;
   localparam int SRCADDR_LSB  = 72;

   localparam datamode_t DM_BYTE = 2'd0;
   localparam datamode_t DM_HALF = 2'd1;
   localparam datamode_t DM_WORD = 2'd2;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;

   localparam addr_t RETURN_ADDR  = 32'h0000_0810;  // where read responses come back
   localparam data_t TIMEOUT_DATA = 32'hDEADBEEF;

   localparam int TIMEOUT_CYCLES = 64;
   localparam int TIMEOUT_W      = 7;
   localparam int WQ_DEPTH       = 4;
   localparam int WQ_PTR_W       = 2;

   typedef enum logic [1:0] {IDLE, ARMED, EXPIRED} timeout_state_t;

   // mesh packet encoder, ctrlmode left at zero
   function automatic packet_t pack_packet(input logic write, input datamode_t mode,
                                           input addr_t dst, input data_t data,
                                           input addr_t src);
      packet_t pkt;
      pkt = '0;
      pkt[WRITE_LSB]           = write;
      pkt[DATAMODE_LSB +: 2]   = mode;
      pkt[DSTADDR_LSB +: 32]   = dst;
      pkt[DATA_LSB +: 32]      = data;
      pkt[SRCADDR_LSB +: 32]   = src;
      return pkt;
   endfunction

endpackage

`default_nettype wire

/* hdl/read_timeout.sv */
`timescale 1ns/100ps
`default_nettype none

module read_timeout (
   input  wire   s_axi_aclk,
   input  wire   s_axi_aresetn,
   input  wire   arm,            // AR handshake
   input  wire   response_seen,
   output logic  expired         // one cycle
);
   import esaxi_pkg::*;

   timeout_state_t       state;
   logic [TIMEOUT_W-1:0] counter;

   assign expired = (state == EXPIRED);

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         state <= IDLE;
      else
         case (state)
            IDLE:    if (arm) state <= ARMED;
            ARMED:
               if (response_seen)
                  state <= IDLE;      // answer wins over terminal count
               else if (counter == '0)
                  state <= EXPIRED;
            default: state <= IDLE;   // single pulse
         endcase
   end

   // arm cycle and EXPIRED entry make up the last two cycles
   always_ff @(posedge s_axi_aclk)
   begin
      if (state == IDLE)
         counter <= TIMEOUT_W'(TIMEOUT_CYCLES - 2);
      else if (state == ARMED)
         counter <= counter - 1'b1;
   end

endmodule

`default_nettype wire

/* hdl/axi_write_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_write_slave (
   input  wire                  s_axi_aclk,
   input  wire                  s_axi_aresetn,
   input  esaxi_pkg::addr_t     s_axi_awaddr,
   input  wire                  s_axi_awvalid,
   output logic                 s_axi_awready,
   input  esaxi_pkg::data_t     s_axi_wdata,
   input  esaxi_pkg::strb_t     s_axi_wstrb,
   input  wire                  s_axi_wvalid,
   output logic                 s_axi_wready,
   output esaxi_pkg::resp_t     s_axi_bresp,
   output logic                 s_axi_bvalid,
   input  wire                  s_axi_bready,
   input  wire                  room,
   output logic                 push,
   output esaxi_pkg::packet_t   push_packet
);
   import esaxi_pkg::*;

   typedef enum logic [1:0] {WAIT_ADDR, WAIT_DATA, WAIT_RESP} write_phase_t;

   write_phase_t phase;
   addr_t        awaddr_q;     // captured on AW
   logic         aw_hs;
   logic         w_hs;
   logic         b_hs;
   logic [1:0]   lane;         // lowest enabled byte lane
   logic [2:0]   lanes_on;
   datamode_t    mode;
   data_t        data_aligned;

   assign aw_hs = s_axi_awvalid & s_axi_awready;
   assign w_hs  = s_axi_wvalid & s_axi_wready;
   assign b_hs  = s_axi_bvalid & s_axi_bready;

   assign s_axi_bresp = RESP_OKAY;  // mesh writes are posted

   // ##############################
   // lane alignment
   // ##############################
   always_comb
   begin
      if (s_axi_wstrb[0])
         lane = 2'd0;
      else if (s_axi_wstrb[1])
         lane = 2'd1;
      else if (s_axi_wstrb[2])
         lane = 2'd2;
      else
         lane = 2'd3;  // top lane, or no strobe at all
      lanes_on = 3'($countones(s_axi_wstrb));
      case (lanes_on)
         3'd4:    mode = DM_WORD;
         3'd2:    mode = DM_HALF;
         default: mode = DM_BYTE;
      endcase
      data_aligned = s_axi_wdata >> {lane, 3'b000};  // shift down k bytes
   end

   // ##############################
   // handshake phases
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         phase         <= WAIT_ADDR;
         s_axi_awready <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
         push          <= 1'b0;
      end
      else
      begin
         push <= w_hs;  // packet goes out one edge after W
         case (phase)
            WAIT_ADDR:
               if (aw_hs)
               begin
                  s_axi_awready <= 1'b0;
                  s_axi_wready  <= room;
                  phase         <= WAIT_DATA;
               end
               else
                  s_axi_awready <= 1'b1;  // first cycle out of reset
            WAIT_DATA:
               if (w_hs)
               begin
                  s_axi_wready <= 1'b0;
                  s_axi_bvalid <= 1'b1;
                  phase        <= WAIT_RESP;
               end
               else
                  s_axi_wready <= room;   // held off while queue full
            default:
               if (b_hs)
               begin
                  s_axi_bvalid  <= 1'b0;
                  s_axi_awready <= 1'b1;
                  phase         <= WAIT_ADDR;
               end
         endcase
      end
   end

   // payload regs
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
         awaddr_q <= s_axi_awaddr;
      if (w_hs)
         push_packet <= pack_packet(1'b1, mode, {awaddr_q[31:2], lane},
                                    data_aligned, '0);
   end

endmodule

`default_nettype wire

/* hdl/write_packet_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module write_packet_queue (
   input  wire                  s_axi_aclk,
   input  wire                  s_axi_aresetn,
   input  wire                  push,
   input  esaxi_pkg::packet_t   push_packet,
   output logic                 room,
   output logic                 wr_access,
   output esaxi_pkg::packet_t   wr_packet,
   input  wire                  wr_wait
);
   import esaxi_pkg::*;

   packet_t             mem [WQ_DEPTH];
   logic [WQ_PTR_W-1:0] wr_ptr;
   logic [WQ_PTR_W-1:0] rd_ptr;
   logic [WQ_PTR_W:0]   count;   // one extra bit for full
   logic                pop;

   // head entry shown while anything is queued
   assign wr_access = (count != '0);
   assign wr_packet = mem[rd_ptr];
   assign room      = (count != (WQ_PTR_W+1)'(WQ_DEPTH));
   assign pop       = wr_access & ~wr_wait;  // mesh takes it this edge

   // ##############################
   // pointers and count
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (push)
         mem[wr_ptr] <= push_packet;
   end

endmodule

`default_nettype wire

/* hdl/axi_read_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_read_slave (
   input  wire                  s_axi_aclk,
   input  wire                  s_axi_aresetn,
   input  esaxi_pkg::addr_t     s_axi_araddr,
   input  wire                  s_axi_arvalid,
   output logic                 s_axi_arready,
   output esaxi_pkg::data_t     s_axi_rdata,
   output esaxi_pkg::resp_t     s_axi_rresp,
   output logic                 s_axi_rvalid,
   input  wire                  s_axi_rready,
   output logic                 rd_access,
   output esaxi_pkg::packet_t   rd_packet,
   input  wire                  rd_wait,
   input  wire                  rr_access,
   input  esaxi_pkg::packet_t   rr_packet
);
   import esaxi_pkg::*;

   typedef enum logic [1:0] {READ_ADDR, READ_WAIT, READ_DATA} read_phase_t;

   read_phase_t phase;
   logic        ar_hs;
   logic        r_hs;
   logic        response_seen;  // rr only counts while waiting
   logic        expired;

   assign ar_hs         = s_axi_arvalid & s_axi_arready;
   assign r_hs          = s_axi_rvalid & s_axi_rready;
   assign response_seen = rr_access & (phase == READ_WAIT);

   read_timeout timeout_i (
      .s_axi_aclk,
      .s_axi_aresetn,
      .arm           (ar_hs),
      .response_seen (response_seen),
      .expired       (expired)
   );

   // ##############################
   // control
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         phase         <= READ_ADDR;
         s_axi_arready <= 1'b0;
         s_axi_rvalid  <= 1'b0;
         rd_access     <= 1'b0;
      end
      else
      begin
         if (ar_hs)
            rd_access <= 1'b1;  // request out next cycle
         else if (!rd_wait)
            rd_access <= 1'b0;  // taken by mesh
         case (phase)
            READ_ADDR:
               if (ar_hs)
               begin
                  s_axi_arready <= 1'b0;
                  phase         <= READ_WAIT;
               end
               else
                  s_axi_arready <= 1'b1;
            READ_WAIT:
               if (response_seen | expired)
               begin
                  s_axi_rvalid <= 1'b1;
                  phase        <= READ_DATA;
               end
            default:
               if (r_hs)
               begin
                  s_axi_rvalid  <= 1'b0;
                  s_axi_arready <= 1'b1;  // next read may start
                  phase         <= READ_ADDR;
               end
         endcase
      end
   end

   // ##############################
   // request and response payload
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_hs)
         rd_packet <= pack_packet(1'b0, DM_WORD, s_axi_araddr, '0, RETURN_ADDR);
      if (response_seen)
      begin
         s_axi_rdata <= rr_packet[DATA_LSB +: 32];
         s_axi_rresp <= RESP_OKAY;
      end
      else if (expired && phase == READ_WAIT)
      begin
         s_axi_rdata <= TIMEOUT_DATA;  // mesh never answered
         s_axi_rresp <= RESP_SLVERR;
      end
   end

endmodule

`default_nettype wire

/* hdl/esaxi.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi (
   input  wire                  s_axi_aclk,
   input  wire                  s_axi_aresetn,
   // write address
   input  esaxi_pkg::addr_t     s_axi_awaddr,
   input  wire                  s_axi_awvalid,
   output logic                 s_axi_awready,
   // write data
   input  esaxi_pkg::data_t     s_axi_wdata,
   input  esaxi_pkg::strb_t     s_axi_wstrb,
   input  wire                  s_axi_wvalid,
   output logic                 s_axi_wready,
   // write response
   output esaxi_pkg::resp_t     s_axi_bresp,
   output logic                 s_axi_bvalid,
   input  wire                  s_axi_bready,
   // read address
   input  esaxi_pkg::addr_t     s_axi_araddr,
   input  wire                  s_axi_arvalid,
   output logic                 s_axi_arready,
   // read data
   output esaxi_pkg::data_t     s_axi_rdata,
   output esaxi_pkg::resp_t     s_axi_rresp,
   output logic                 s_axi_rvalid,
   input  wire                  s_axi_rready,
   // mesh side
   output logic                 wr_access,
   output esaxi_pkg::packet_t   wr_packet,
   input  wire                  wr_wait,
   output logic                 rd_access,
   output esaxi_pkg::packet_t   rd_packet,
   input  wire                  rd_wait,
   input  wire                  rr_access,
   input  esaxi_pkg::packet_t   rr_packet,
   output logic                 rr_wait
);
   import esaxi_pkg::*;

   logic    push;         // one cycle per accepted W beat
   packet_t push_packet;
   logic    room;         // queue not full

   // ##############################
   // write path
   // ##############################
   axi_write_slave write_slave_i (
      .s_axi_aclk, .s_axi_aresetn,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .room, .push, .push_packet
   );

   write_packet_queue write_queue_i (
      .s_axi_aclk, .s_axi_aresetn,
      .push, .push_packet, .room,
      .wr_access, .wr_packet, .wr_wait
   );

   // ##############################
   // read path
   // ##############################
   axi_read_slave read_slave_i (
      .s_axi_aclk, .s_axi_aresetn,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
      .rd_access, .rd_packet, .rd_wait,
      .rr_access, .rr_packet
   );

   assign rr_wait = 1'b0;  // responses never stalled, one read in flight

endmodule

`default_nettype wire

/* verif/esaxi_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_sva (
   input wire                 s_axi_aclk,
   input wire                 s_axi_aresetn,
   input wire                 s_axi_awready,
   input wire                 s_axi_arready,
   input wire                 s_axi_bvalid,
   input wire                 s_axi_bready,
   input wire                 s_axi_rvalid,
   input wire                 s_axi_rready,
   input esaxi_pkg::data_t    s_axi_rdata,
   input wire                 wr_access,
   input wire                 wr_wait,
   input esaxi_pkg::packet_t  wr_packet
);
   logic in_reset_q = 1'b0;  // reset was low on the previous edge too

   always @(posedge s_axi_aclk)
      in_reset_q <= !s_axi_aresetn;

   // ##############################
   // handshake rules
   // ##############################
   a_reset_quiet: assert property (@(posedge s_axi_aclk)
      (!s_axi_aresetn && in_reset_q) |->
         !(s_axi_awready | s_axi_arready | s_axi_bvalid | s_axi_rvalid))
      else $error("handshake output high during reset");

   a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
      else $error("bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      (s_axi_rvalid && !s_axi_rready) |=> (s_axi_rvalid && $stable(s_axi_rdata)))
      else $error("rvalid or rdata changed before rready");

   // mesh rule, packet parked while stalled
   a_wr_stall: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      (wr_access && wr_wait) |=> (wr_access && $stable(wr_packet)))
      else $error("wr_packet changed while wr_wait was high");

endmodule

`default_nettype wire

/* verif/esaxi_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module esaxi_tb;
   import esaxi_pkg::*;

   localparam int NUM_WRITES      = 100;
   localparam int NUM_READS       = 80;
   localparam int NUM_TIMEOUTS    = 6;   // each followed by a normal read
   localparam int WATCHDOG_CYCLES = 200 * (TIMEOUT_CYCLES + 40);

   logic    s_axi_aclk;
   logic    s_axi_aresetn;
   addr_t   s_axi_awaddr;
   logic    s_axi_awvalid;
   logic    s_axi_awready;
   data_t   s_axi_wdata;
   strb_t   s_axi_wstrb;
   logic    s_axi_wvalid;
   logic    s_axi_wready;
   resp_t   s_axi_bresp;
   logic    s_axi_bvalid;
   logic    s_axi_bready;
   addr_t   s_axi_araddr;
   logic    s_axi_arvalid;
   logic    s_axi_arready;
   data_t   s_axi_rdata;
   resp_t   s_axi_rresp;
   logic    s_axi_rvalid;
   logic    s_axi_rready;
   logic    wr_access;
   packet_t wr_packet;
   logic    wr_wait;
   logic    rd_access;
   packet_t rd_packet;
   logic    rd_wait;
   logic    rr_access;
   packet_t rr_packet;
   logic    rr_wait;

   integer  seed;
   packet_t exp_wr [$];     // scoreboard, issue order
   packet_t exp_p;
   addr_t   cur_read_addr;
   logic    no_answer;      // mesh stays silent for this read
   int      errors;
   int      checks;
   int      errors_at_start;
   int      writes_seen;
   int      bresps_seen;
   int      requests_seen;
   int      delay;
   logic    next_wr_wait;
   logic    next_rd_wait;
   data_t   got_rdata;
   resp_t   got_rresp;

   esaxi dut_i (.*);

   bind esaxi esaxi_sva sva_i (.*);

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #2 s_axi_aclk = ~s_axi_aclk;
   end

   // ##############################
   // helpers and reference model
   // ##############################
   function int random_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function logic random_bit();
      return ($random(seed) & 1) != 0;
   endfunction

   function automatic strb_t random_strobe();
      strb_t pats [7];
      pats = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
      return pats[random_below(7)];
   endfunction

   function automatic data_t mem_word(input addr_t a);
      return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;  // every address bit counts
   endfunction

   // alignment rule: lowest lane k, mode from lane count
   function automatic packet_t expected_write(input addr_t a, input data_t d, input strb_t s);
      int      k;
      int      n;
      packet_t p;
      k = 0;
      while (k < 3 && !s[k])
         k++;
      n = $countones(s);
      p = '0;
      p[WRITE_LSB]            = 1'b1;
      p[DATAMODE_LSB +: 2]    = (n == 4) ? 2'd2 : (n == 2) ? 2'd1 : 2'd0;
      p[DSTADDR_LSB +: 32]    = {a[31:2], 2'(k)};
      p[DATA_LSB +: 32]       = d >> (8 * k);
      return p;
   endfunction

   task automatic check_value(input string name, input logic [103:0] expected,
                              input logic [103:0] actual);
      checks++;
      assert (expected === actual)
      else
      begin
         $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      $display("test %-8s done, %0d errors", name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   // ##############################
   // AXI drivers
   // ##############################
   task automatic do_write(input addr_t addr, input data_t data, input strb_t strb);
      logic aw_hit;
      logic w_hit;
      logic aw_done;
      logic w_done;
      logic b_done;
      exp_wr.push_back(expected_write(addr, data, strb));
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_wvalid  = 1'b1;
      s_axi_bready  = 1'b0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      while (!(aw_done && w_done))
      begin
         @(negedge s_axi_aclk);
         aw_hit = s_axi_awvalid && s_axi_awready;  // taken on next edge
         w_hit  = s_axi_wvalid && s_axi_wready;
         @(posedge s_axi_aclk);
         #1;
         if (aw_hit)
         begin
            s_axi_awvalid = 1'b0;
            aw_done       = 1'b1;
         end
         if (w_hit)
         begin
            s_axi_wvalid = 1'b0;
            w_done       = 1'b1;
         end
      end
      b_done = 1'b0;
      while (!b_done)
      begin
         @(negedge s_axi_aclk);
         b_done = s_axi_bvalid && s_axi_bready;
         @(posedge s_axi_aclk);
         #1;
         s_axi_bready = b_done ? 1'b0 : random_bit();  // random back-pressure
      end
   endtask

   task automatic do_read(input addr_t addr, input logic timeout_test);
      logic ar_hit;
      logic r_done;
      cur_read_addr = addr;
      no_answer     = timeout_test;
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      s_axi_rready  = 1'b0;
      ar_hit = 1'b0;
      while (!ar_hit)
      begin
         @(negedge s_axi_aclk);
         ar_hit = s_axi_arvalid && s_axi_arready;
         @(posedge s_axi_aclk);
         #1;
      end
      s_axi_arvalid = 1'b0;
      r_done = 1'b0;
      while (!r_done)
      begin
         @(negedge s_axi_aclk);
         r_done    = s_axi_rvalid && s_axi_rready;
         got_rdata = s_axi_rdata;
         got_rresp = s_axi_rresp;
         @(posedge s_axi_aclk);
         #1;
         s_axi_rready = r_done ? 1'b0 : random_bit();
      end
      if (timeout_test)
      begin
         check_value("s_axi_rdata", TIMEOUT_DATA, got_rdata);
         check_value("s_axi_rresp", RESP_SLVERR, got_rresp);
      end
      else
      begin
         check_value("s_axi_rdata", mem_word(addr), got_rdata);
         check_value("s_axi_rresp", RESP_OKAY, got_rresp);
      end
   endtask

   // ##############################
   // mesh model and monitors
   // ##############################
   always
   begin
      @(negedge s_axi_aclk);
      next_wr_wait = (random_below(3) == 0);  // stall about a third of cycles
      next_rd_wait = (random_below(3) == 0);
      @(posedge s_axi_aclk);
      #1;
      wr_wait = next_wr_wait;
      rd_wait = next_rd_wait;
   end

   always @(negedge s_axi_aclk)
   begin
      if (s_axi_aresetn && wr_access && !wr_wait)
      begin
         writes_seen++;
         assert (exp_wr.size() != 0)
         else
         begin
            $display("[ERROR] %0t write packet reached the mesh with none expected", $time);
            errors++;
         end
         if (exp_wr.size() != 0)
         begin
            exp_p = exp_wr.pop_front();
            check_value("wr_packet", exp_p, wr_packet);
         end
      end
      if (s_axi_aresetn && s_axi_bvalid && s_axi_bready)
      begin
         bresps_seen++;
         check_value("s_axi_bresp", RESP_OKAY, s_axi_bresp);
      end
   end

   // read responder, one request at a time
   always @(negedge s_axi_aclk)
   begin
      if (s_axi_aresetn && rd_access && !rd_wait)
      begin
         requests_seen++;
         check_value("rd_packet write", 1'b0, rd_packet[WRITE_LSB]);
         check_value("rd_packet datamode", 2'd2, rd_packet[DATAMODE_LSB +: 2]);
         check_value("rd_packet dstaddr", cur_read_addr, rd_packet[DSTADDR_LSB +: 32]);
         check_value("rd_packet srcaddr", RETURN_ADDR, rd_packet[SRCADDR_LSB +: 32]);
         check_value("rr_wait", 1'b0, rr_wait);  // responses are never stalled
         if (!no_answer)
         begin
            @(posedge s_axi_aclk);  // request taken here
            delay = 1 + random_below(20);
            repeat (delay - 1) @(posedge s_axi_aclk);
            #1;
            rr_packet                      = '0;
            rr_packet[WRITE_LSB]           = 1'b1;
            rr_packet[DATAMODE_LSB +: 2]   = 2'd2;
            rr_packet[DSTADDR_LSB +: 32]   = RETURN_ADDR;
            rr_packet[DATA_LSB +: 32]      = mem_word(cur_read_addr);
            rr_access = 1'b1;
            @(posedge s_axi_aclk);
            #1;
            rr_access = 1'b0;
         end
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge s_axi_aclk);
      $display("watchdog: run still busy after %0d cycles, DUT hung", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   // ##############################
   // test sequence
   // ##############################
   initial
   begin
      seed = 32'h455;
      errors = 0;
      checks = 0;
      errors_at_start = 0;
      writes_seen = 0;
      bresps_seen = 0;
      requests_seen = 0;
      no_answer = 1'b0;
      cur_read_addr = '0;
      s_axi_aresetn = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      wr_wait   = 1'b0;
      rd_wait   = 1'b0;
      rr_access = 1'b0;
      rr_packet = '0;

      repeat (2) @(posedge s_axi_aclk);
      @(negedge s_axi_aclk);
      check_value("s_axi_awready", 1'b0, s_axi_awready);
      check_value("s_axi_wready", 1'b0, s_axi_wready);
      check_value("s_axi_bvalid", 1'b0, s_axi_bvalid);
      check_value("s_axi_arready", 1'b0, s_axi_arready);
      check_value("s_axi_rvalid", 1'b0, s_axi_rvalid);
      check_value("wr_access", 1'b0, wr_access);
      check_value("rd_access", 1'b0, rd_access);
      repeat (3) @(posedge s_axi_aclk);
      #1;
      s_axi_aresetn = 1'b1;
      @(posedge s_axi_aclk);
      @(negedge s_axi_aclk);  // first cycle out of reset
      check_value("s_axi_awready", 1'b1, s_axi_awready);
      check_value("s_axi_arready", 1'b1, s_axi_arready);
      @(posedge s_axi_aclk);
      #1;
      report_test("reset");

      for (int i = 0; i < NUM_WRITES; i++)
         do_write($random(seed), $random(seed), random_strobe());
      while (exp_wr.size() != 0)
         @(posedge s_axi_aclk);
      repeat (20) @(posedge s_axi_aclk);  // room for a stray duplicate
      #1;
      check_value("write packet count", NUM_WRITES, writes_seen);
      check_value("bresp count", NUM_WRITES, bresps_seen);
      report_test("writes");

      for (int i = 0; i < NUM_READS; i++)
         do_read($random(seed), 1'b0);
      report_test("reads");

      for (int i = 0; i < NUM_TIMEOUTS; i++)
      begin
         do_read($random(seed), 1'b1);
         do_read($random(seed), 1'b0);
      end
      check_value("read request count", NUM_READS + 2 * NUM_TIMEOUTS, requests_seen);
      report_test("timeouts");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
hdl/esaxi_pkg.sv
hdl/read_timeout.sv
hdl/axi_write_slave.sv
hdl/write_packet_queue.sv
hdl/axi_read_slave.sv
hdl/esaxi.sv
verif/esaxi_sva.sv
verif/esaxi_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = esaxi_tb
FILELIST   = build.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
OBJ_DIR    = obj_dir
LOG        = run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
